// ==== list.f ====
+incdir+source
source/a2bus_pkg.sv
source/phase_denoise.sv
source/bus_decode.sv
source/card_execute.sv
source/bus_result.sv
source/a2_slot_bus.sv
tb/tb_clock.sv
tb/tb_a2_slot_bus.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the slot bus testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_a2_slot_bus -o tb_a2_slot_bus_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_a2_slot_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" sim.log; then
    exit 0
else
    exit 1
fi

// ==== source/a2_settings.svh ====
`default_nettype none

`ifndef A2_SETTINGS_SVH
`define A2_SETTINGS_SVH

// Apple II bus widths
`define A2_ADDR_W 16
`define A2_DATA_W 8

// Peripheral cards and the slots they answer in
`define NUM_CARDS 3
`define CARD0_SLOT 2
`define CARD1_SLOT 4
`define CARD2_SLOT 5

`define CARD_REGS 4     // Offsets 4..15 alias onto 0..3

// Majority window on the synchronized phi1
`define DENOISE_LEN 3

`endif

`default_nettype wire

// ==== source/a2_slot_bus.sv ====
`timescale 1ns/100ps
`include "a2_settings.svh"
`default_nettype none

module a2_slot_bus (
    input  logic                  clk_logic_w,
    input  logic                  reset_i,
    input  logic                  a2_phi1_i,
    input  logic [`A2_ADDR_W-1:0] a2_addr_i,
    input  logic [`A2_DATA_W-1:0] a2_data_i,
    input  logic                  a2_rw_n_i,
    output logic [`A2_DATA_W-1:0] data_out_o,
    output logic                  data_out_en_o,
    output logic                  irq_n_o,
    output logic [`NUM_CARDS-1:0] led_o
);
    import a2bus_pkg::*;

    logic       phi1_rise_w;
    bus_cycle_t cyc_w;
    logic       req_w;
    logic       ack_w;
    logic       idle_cycle_w;
    card_resp_t resp_w;

    // Phi1 into the logic clock domain
    phase_denoise phase_denoise_inst (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .phi1_i      (a2_phi1_i),
        .phi1_rise_o (phi1_rise_w)
    );

    bus_decode bus_decode_inst (
        .clk_logic_w  (clk_logic_w),
        .reset_i      (reset_i),
        .phi1_rise_i  (phi1_rise_w),
        .addr_i       (a2_addr_i),
        .data_i       (a2_data_i),
        .rw_n_i       (a2_rw_n_i),
        .cyc_o        (cyc_w),
        .req_o        (req_w),
        .ack_i        (ack_w),
        .idle_cycle_o (idle_cycle_w)
    );

    card_execute card_execute_inst (
        .clk_logic_w (clk_logic_w),
        .reset_i     (reset_i),
        .cyc_i       (cyc_w),
        .req_i       (req_w),
        .ack_o       (ack_w),
        .resp_o      (resp_w)
    );

    // Drives the pad enable, the buffer itself sits outside
    bus_result bus_result_inst (
        .clk_logic_w   (clk_logic_w),
        .reset_i       (reset_i),
        .resp_i        (resp_w),
        .idle_cycle_i  (idle_cycle_w),
        .data_out_o    (data_out_o),
        .data_out_en_o (data_out_en_o),
        .irq_n_o       (irq_n_o),
        .led_o         (led_o)
    );

endmodule

`default_nettype wire

// ==== source/a2bus_pkg.sv ====
`include "a2_settings.svh"
`default_nettype none

package a2bus_pkg;

    // Class of a decoded bus cycle
    typedef enum logic [0:0] {
        ACC_NONE,
        ACC_DEVSEL
    } access_e;

    // Four-phase handshake on the decode side
    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_REQ,
        DEC_WAIT_ACK_LOW
    } dec_state_e;

    // One captured bus cycle, handed from decode to execute
    typedef struct packed {
        logic [1:0]            card;      // Card index, not the slot number
        logic [1:0]            reg_sel;
        logic                  rw_n;
        logic [`A2_DATA_W-1:0] wdata;
        access_e               kind;
    } bus_cycle_t;

    // What execute reports back for the result stage
    typedef struct packed {
        logic                  rd_en;
        logic [`A2_DATA_W-1:0] rdata;
        logic [`NUM_CARDS-1:0] irq_n;     // One per card, active low
        logic                  valid;     // Pulses once per completed access
    } card_resp_t;

endpackage

`default_nettype wire

// ==== source/bus_decode.sv ====
`timescale 1ns/100ps
`include "a2_settings.svh"
`default_nettype none

module bus_decode (
    input  logic                  clk_logic_w,
    input  logic                  reset_i,
    input  logic                  phi1_rise_i,
    input  logic [`A2_ADDR_W-1:0] addr_i,
    input  logic [`A2_DATA_W-1:0] data_i,
    input  logic                  rw_n_i,
    output a2bus_pkg::bus_cycle_t cyc_o,
    output logic                  req_o,
    input  logic                  ack_i,
    output logic                  idle_cycle_o
);
    import a2bus_pkg::*;

    dec_state_e state_q;
    dec_state_e state_d;
    bus_cycle_t cyc_w;
    bus_cycle_t cyc_q;
    logic       io_space_w;
    logic       slot_hit_w;
    logic [1:0] card_w;
    logic       capture_w;
    logic       idle_q;

    assign io_space_w = (addr_i[15:7] == 9'b1100_0000_1);  // $C080-$C0FF, bit 7 always set

    // Slot field is bits 6:4 inside the device-select range
    always_comb begin
        slot_hit_w = 1'b1;
        card_w     = 2'd0;
        case (addr_i[6:4])
            `CARD0_SLOT: card_w = 2'd0;
            `CARD1_SLOT: card_w = 2'd1;
            `CARD2_SLOT: card_w = 2'd2;
            default:     slot_hit_w = 1'b0;
        endcase
    end

    always_comb begin
        cyc_w.card    = card_w;
        cyc_w.reg_sel = addr_i[1:0];         // Upper offset bits alias
        cyc_w.rw_n    = rw_n_i;
        cyc_w.wdata   = data_i;
        cyc_w.kind    = (io_space_w && slot_hit_w) ? ACC_DEVSEL : ACC_NONE;
    end

    // A new cycle is only taken with the handshake fully back to zero
    assign capture_w = phi1_rise_i && (state_q == DEC_IDLE) && (cyc_w.kind == ACC_DEVSEL);

    always_comb begin
        state_d = state_q;
        case (state_q)
            DEC_IDLE:         if (capture_w) state_d = DEC_REQ;
            DEC_REQ:          if (ack_i) state_d = DEC_WAIT_ACK_LOW;
            DEC_WAIT_ACK_LOW: if (!ack_i) state_d = DEC_IDLE;
            default:          state_d = DEC_IDLE;
        endcase
    end

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            state_q <= DEC_IDLE;
            idle_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            idle_q  <= phi1_rise_i && (state_q == DEC_IDLE) && (cyc_w.kind == ACC_NONE);
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (capture_w) begin
            cyc_q <= cyc_w;
        end
    end

    assign cyc_o        = cyc_q;
    assign req_o        = (state_q == DEC_REQ);
    assign idle_cycle_o = idle_q;

    // Payload must hold for the whole request phase
    a_cyc_stable: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        req_o |=> (!req_o || $stable(cyc_o)));

    // A phi1 edge landing mid-handshake loses that bus cycle
    a_no_overrun: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        phi1_rise_i |-> !(req_o || ack_i))
        else $error("bus cycle dropped, handshake still busy");

endmodule

`default_nettype wire

// ==== source/bus_result.sv ====
`timescale 1ns/100ps
`include "a2_settings.svh"
`default_nettype none

module bus_result (
    input  logic                  clk_logic_w,
    input  logic                  reset_i,
    input  a2bus_pkg::card_resp_t resp_i,
    input  logic                  idle_cycle_i,
    output logic [`A2_DATA_W-1:0] data_out_o,
    output logic                  data_out_en_o,
    output logic                  irq_n_o,
    output logic [`NUM_CARDS-1:0] led_o
);

    logic [`A2_DATA_W-1:0] data_q;
    logic                  en_q;
    logic                  irq_n_q;
    logic [`NUM_CARDS-1:0] led_q;

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            en_q    <= 1'b0;
            irq_n_q <= 1'b1;
            led_q   <= '0;
        end else begin
            if (resp_i.valid) begin
                en_q <= resp_i.rd_en;   // A write answers with the bus released
            end else if (idle_cycle_i) begin
                en_q <= 1'b0;
            end
            irq_n_q <= &resp_i.irq_n;   // Shared open-drain style IRQ line
            led_q   <= ~resp_i.irq_n;   // LED lit while its card interrupts
        end
    end

    // Read byte held until the next response
    always_ff @(posedge clk_logic_w) begin
        if (resp_i.valid) begin
            data_q <= resp_i.rdata;
        end
    end

    assign data_out_o    = data_q;
    assign data_out_en_o = en_q;
    assign irq_n_o       = irq_n_q;
    assign led_o         = led_q;

endmodule

`default_nettype wire

// ==== source/card_execute.sv ====
`timescale 1ns/100ps
`include "a2_settings.svh"
`default_nettype none

module card_execute (
    input  logic                  clk_logic_w,
    input  logic                  reset_i,
    input  a2bus_pkg::bus_cycle_t cyc_i,
    input  logic                  req_i,
    output logic                  ack_o,
    output a2bus_pkg::card_resp_t resp_o
);
    import a2bus_pkg::*;

    localparam int REG_IRQ_EN   = 2;   // Bit 0 enables the card interrupt
    localparam int REG_IRQ_FLAG = 3;   // Bit 7 is the pending flag

    logic [`A2_DATA_W-1:0] regs_q [`NUM_CARDS][`CARD_REGS];
    logic                  ack_q;
    logic                  valid_q;
    logic                  rd_en_q;
    logic [`A2_DATA_W-1:0] rdata_q;
    logic [`NUM_CARDS-1:0] irq_n_w;
    logic                  start_w;
    logic                  access_w;

    assign start_w  = req_i && !ack_q;   // First cycle of a new request
    assign access_w = (cyc_i.kind == ACC_DEVSEL) && (cyc_i.card < `NUM_CARDS);

    always_comb begin
        for (int c = 0; c < `NUM_CARDS; c++) begin
            irq_n_w[c] = ~(regs_q[c][REG_IRQ_EN][0] & regs_q[c][REG_IRQ_FLAG][7]);
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            ack_q   <= 1'b0;
            valid_q <= 1'b0;
            rd_en_q <= 1'b0;
            for (int c = 0; c < `NUM_CARDS; c++) begin
                for (int r = 0; r < `CARD_REGS; r++) begin
                    regs_q[c][r] <= '0;
                end
            end
        end else begin
            valid_q <= start_w;
            if (start_w) begin
                ack_q   <= 1'b1;
                rd_en_q <= access_w && cyc_i.rw_n;
                if (access_w && !cyc_i.rw_n) begin
                    regs_q[cyc_i.card][cyc_i.reg_sel] <= cyc_i.wdata;
                end else if (access_w && cyc_i.reg_sel == 2'(REG_IRQ_FLAG)) begin
                    // Read acknowledges the interrupt, old value still goes out
                    regs_q[cyc_i.card][REG_IRQ_FLAG][7] <= 1'b0;
                end
            end else if (!req_i) begin
                ack_q <= 1'b0;
            end
        end
    end

    // Read data sampled before any flag clear lands
    always_ff @(posedge clk_logic_w) begin
        if (start_w && access_w) begin
            rdata_q <= regs_q[cyc_i.card][cyc_i.reg_sel];
        end
    end

    assign ack_o        = ack_q;
    assign resp_o.rd_en = rd_en_q;
    assign resp_o.rdata = rdata_q;
    assign resp_o.irq_n = irq_n_w;
    assign resp_o.valid = valid_q;

    a_ack_needs_req: assert property (@(posedge clk_logic_w) disable iff (reset_i)
        $rose(ack_o) |-> req_i);

endmodule

`default_nettype wire

// ==== source/phase_denoise.sv ====
`timescale 1ns/100ps
`include "a2_settings.svh"
`default_nettype none

module phase_denoise (
    input  logic clk_logic_w,
    input  logic reset_i,
    input  logic phi1_i,
    output logic phi1_rise_o
);

    logic [1:0]              sync_q;
    logic [`DENOISE_LEN-2:0] hist_q;     // Older samples, newest in bit 0
    logic [`DENOISE_LEN-1:0] window_w;
    logic                    level_q;
    logic                    level_d;

    // Newest synchronized sample plus the history makes the window
    assign window_w = {hist_q, sync_q[1]};

    always_comb begin
        level_d = level_q;
        if (&window_w) begin
            level_d = 1'b1;
        end else if (~|window_w) begin
            level_d = 1'b0;
        end
    end

    assign phi1_rise_o = level_d & ~level_q;  // One cycle, the level flips right after

    always_ff @(posedge clk_logic_w) begin
        if (reset_i) begin
            sync_q  <= '0;
            hist_q  <= '0;
            level_q <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], phi1_i};
            hist_q  <= {hist_q[`DENOISE_LEN-3:0], sync_q[1]};
            level_q <= level_d;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_a2_slot_bus.sv ====
`timescale 1ns/100ps
`include "a2_settings.svh"
`default_nettype none

module tb_a2_slot_bus;

    // One bus cycle of the stimulus table with what the bus should show afterwards
    typedef struct packed {
        logic [`A2_ADDR_W-1:0] addr;
        logic [`A2_DATA_W-1:0] data;
        logic                  rw_n;
        logic                  exp_resp;   // Read answered with data_out_en_o high
        logic [`A2_DATA_W-1:0] exp_data;
        logic                  exp_irq_n;
        logic [`NUM_CARDS-1:0] exp_led;
    } row_t;

    logic                  clk_logic_w;
    logic                  reset_i;
    logic                  a2_phi1_i;
    logic [`A2_ADDR_W-1:0] a2_addr_i;
    logic [`A2_DATA_W-1:0] a2_data_i;
    logic                  a2_rw_n_i;
    logic [`A2_DATA_W-1:0] data_out_o;
    logic                  data_out_en_o;
    logic                  irq_n_o;
    logic [`NUM_CARDS-1:0] led_o;

    row_t                  rows[$];
    logic [`A2_DATA_W-1:0] model_regs [`NUM_CARDS][`CARD_REGS];
    bit                    table_ready;

    tb_clock tb_clock_inst (
        .clk_o   (clk_logic_w),
        .reset_o (reset_i)
    );

    a2_slot_bus a2_slot_bus_inst (
        .clk_logic_w   (clk_logic_w),
        .reset_i       (reset_i),
        .a2_phi1_i     (a2_phi1_i),
        .a2_addr_i     (a2_addr_i),
        .a2_data_i     (a2_data_i),
        .a2_rw_n_i     (a2_rw_n_i),
        .data_out_o    (data_out_o),
        .data_out_en_o (data_out_en_o),
        .irq_n_o       (irq_n_o),
        .led_o         (led_o)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int row_idx,
                               input logic [7:0] got, input logic [7:0] expected);
        assert (got === expected) else begin
            stop_on_error($sformatf("MISMATCH %s row %0d: got 0x%02h expected 0x%02h",
                                    name, row_idx, got, expected));
        end
    endtask

    function automatic int card_of_slot(input logic [2:0] slot);
        case (slot)
            `CARD0_SLOT: return 0;
            `CARD1_SLOT: return 1;
            `CARD2_SLOT: return 2;
            default:     return -1;     // Empty slot
        endcase
    endfunction

    function automatic logic [7:0] rand_byte();
        return 8'($urandom);
    endfunction

    // Reference model: register file per card, IRQ from reg 2 bit 0 and reg 3 bit 7
    task automatic add_cycle(input logic [15:0] addr, input logic [7:0] data, input logic rw_n);
        row_t row;
        int   card;
        int   r;
        row      = '0;
        row.addr = addr;
        row.data = data;
        row.rw_n = rw_n;
        card     = (addr >= 16'hC080 && addr <= 16'hC0FF) ? card_of_slot(addr[6:4]) : -1;
        r        = int'(addr[1:0]);
        if (card >= 0) begin
            if (!rw_n) begin
                model_regs[card][r] = data;
            end else begin
                row.exp_resp = 1'b1;
                row.exp_data = model_regs[card][r];
                if (r == 3) model_regs[card][3][7] = 1'b0;  // Read clears the flag
            end
        end
        row.exp_irq_n = 1'b1;
        for (int c = 0; c < `NUM_CARDS; c++) begin
            if (model_regs[c][2][0] && model_regs[c][3][7]) begin
                row.exp_irq_n  = 1'b0;
                row.exp_led[c] = 1'b1;
            end
        end
        rows.push_back(row);
    endtask

    task automatic build_table();
        for (int c = 0; c < `NUM_CARDS; c++) begin
            for (int r = 0; r < `CARD_REGS; r++) model_regs[c][r] = '0;
        end
        // Write then read back on each card
        add_cycle(16'hC0A0, rand_byte(), 1'b0);
        add_cycle(16'hC0A0, 8'h00, 1'b1);
        add_cycle(16'hC0C1, rand_byte(), 1'b0);
        add_cycle(16'hC0C1, 8'h00, 1'b1);
        add_cycle(16'hC0D0, rand_byte(), 1'b0);
        add_cycle(16'hC0D0, 8'h00, 1'b1);
        // Offsets 1 and 5 hit the same register in slot 2
        add_cycle(16'hC0A1, rand_byte(), 1'b0);
        add_cycle(16'hC0A5, 8'h00, 1'b1);
        add_cycle(16'hC0B0, 8'h00, 1'b1);       // Slot 3 has no card
        add_cycle(16'hC0A5, rand_byte(), 1'b0);
        add_cycle(16'hC0A1, 8'h00, 1'b1);
        add_cycle(16'hC030, 8'h00, 1'b1);       // Below the device-select range
        add_cycle(16'hC0A1, 8'h00, 1'b1);
        add_cycle(16'hC100, 8'h00, 1'b1);       // Card ROM space, not decoded
        add_cycle(16'hC0B2, rand_byte(), 1'b0);
        // Slot 4 interrupt raised, read back and released
        add_cycle(16'hC0C2, 8'h01, 1'b0);
        add_cycle(16'hC0C3, {1'b1, 7'(rand_byte())}, 1'b0);
        add_cycle(16'hC0C3, 8'h00, 1'b1);
        add_cycle(16'hC0C3, 8'h00, 1'b1);
        // Slots 2 and 5 interrupt together
        add_cycle(16'hC0A2, 8'h01, 1'b0);
        add_cycle(16'hC0D2, 8'h01, 1'b0);
        add_cycle(16'hC0A3, {1'b1, 7'(rand_byte())}, 1'b0);
        add_cycle(16'hC0D7, {1'b1, 7'(rand_byte())}, 1'b0);  // Alias of reg 3
        add_cycle(16'hC0A3, 8'h00, 1'b1);
        add_cycle(16'hC0D3, 8'h00, 1'b1);
    endtask

    // Phi1 low 12 cycles, bus set, phi1 high 12 cycles, ends on the last falling edge
    task automatic apply_cycle(input row_t row);
        @(negedge clk_logic_w);
        a2_phi1_i = 1'b0;
        repeat (11) @(negedge clk_logic_w);
        a2_addr_i = row.addr;
        a2_data_i = row.data;
        a2_rw_n_i = row.rw_n;
        @(negedge clk_logic_w);
        a2_phi1_i = 1'b1;
        repeat (11) @(negedge clk_logic_w);
    endtask

    initial begin
        wait (table_ready);
        repeat (rows.size() * 30 + 100) @(posedge clk_logic_w);
        stop_on_error("Timeout: the bus cycles did not complete in the allowed time");
    end

    initial begin
        row_t row;
        a2_phi1_i   = 1'b0;
        a2_addr_i   = '0;
        a2_data_i   = '0;
        a2_rw_n_i   = 1'b1;
        void'($urandom(19));
        build_table();
        table_ready = 1'b1;

        @(negedge clk_logic_w);
        while (reset_i) @(negedge clk_logic_w);
        check_value("data_out_en_o", -1, {7'b0, data_out_en_o}, 8'h00);
        check_value("irq_n_o", -1, {7'b0, irq_n_o}, 8'h01);
        check_value("led_o", -1, {5'b0, led_o}, 8'h00);

        for (int i = 0; i < rows.size(); i++) begin
            row = rows[i];
            apply_cycle(row);
            check_value("data_out_en_o", i, {7'b0, data_out_en_o}, {7'b0, row.exp_resp});
            if (row.exp_resp) begin
                check_value("data_out_o", i, data_out_o, row.exp_data);
            end
            check_value("irq_n_o", i, {7'b0, irq_n_o}, {7'b0, row.exp_irq_n});
            check_value("led_o", i, {5'b0, led_o}, {5'b0, row.exp_led});
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 10,  // 20 ns clock
    parameter int RESET_CYCLES   = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset held high for a fixed count of rising edges
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

`default_nettype wire
